// ==== frame_loader_params.svh ====
`ifndef FRAME_LOADER_PARAMS_SVH
`define FRAME_LOADER_PARAMS_SVH

// stream word and read data width
`define WORD_W 32

// data words after the sync word
`define NUM_WORDS 63

`define SYNC_WORD 32'hF9A42BB1

// read address, 0 is status, 1 to NUM_WORDS are data
`define ADDR_W 6

`endif

// ==== frame_loader_pkg.sv ====
`include "frame_loader_params.svh"

package frame_loader_pkg;

    // host read request
    typedef struct packed {
        logic               req;
        logic [`ADDR_W-1:0] addr;
    } rd_req_t;

    // status word seen at address 0
    typedef struct packed {
        logic [15:0] frame_count;
        logic [14:0] reserved;
        logic        ready;
    } status_t;

    // one read word, decoded by address
    typedef union packed {
        logic [`WORD_W-1:0] raw;
        status_t            status;
    } rd_data_u;

    typedef struct packed {
        logic     ack;
        rd_data_u data;
    } rd_rsp_t;

    // write path into the word store
    typedef struct packed {
        logic               valid;
        logic [`ADDR_W-1:0] index;
        logic [`WORD_W-1:0] data;
    } word_wr_t;

endpackage

// ==== bit_deserializer.sv ====
`timescale 1ns/1ns

`include "frame_loader_params.svh"

module bit_deserializer
(
    input  logic               clk,
    input  logic               reset,
    input  logic               serial_in,
    input  logic               frame_end,
    output logic               word_valid,
    output logic [`WORD_W-1:0] word_data,
    output logic               sync_hit
);

    // shift register, newest bit at the bottom
    logic [`WORD_W-1:0] shift_q;
    logic [`WORD_W-1:0] shift_next;

    // set while looking for the sync word
    logic               hunting;

    // bits taken since sync or since the last word
    logic [4:0]         bit_cnt;

    assign shift_next = {shift_q[`WORD_W-2:0], serial_in};

    // after a word_valid edge the register holds the full word
    assign word_data = shift_q;

    //////////////////////////////////////////////////
    // serial in, sync hunt and word framing
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            shift_q    <= '0;
            hunting    <= 1'b1;
            bit_cnt    <= '0;
            sync_hit   <= 1'b0;
            word_valid <= 1'b0;
        end
        else
        begin
            shift_q    <= shift_next;
            sync_hit   <= 1'b0;
            word_valid <= 1'b0;

            if (frame_end)
            begin
                // frame done, look for the next sync
                hunting <= 1'b1;
                bit_cnt <= '0;
            end
            else if (hunting)
            begin
                if (shift_next == `SYNC_WORD)
                begin
                    sync_hit <= 1'b1;
                    hunting  <= 1'b0;
                    bit_cnt  <= '0;
                end
            end
            else
            begin
                // counter wraps on its own after bit 32
                bit_cnt <= bit_cnt + 5'd1;
                if (bit_cnt == 5'd31)
                begin
                    word_valid <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== frame_sequencer.sv ====
`timescale 1ns/1ns

`include "frame_loader_params.svh"

module frame_sequencer
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       word_valid,
    input  logic [`WORD_W-1:0]         word_data,
    input  logic                       sync_hit,
    output logic                       frame_end,
    output frame_loader_pkg::word_wr_t wr,
    output frame_loader_pkg::status_t  status
);

    // store index for the next word, data starts at 1
    logic [`ADDR_W-1:0] next_index;
    logic               last_word;

    logic               wr_valid_q;
    logic [`ADDR_W-1:0] wr_index_q;
    logic [`WORD_W-1:0] wr_data_q;

    logic               ready_q;
    logic [15:0]        frame_count_q;

    assign last_word = (next_index == `ADDR_W'(`NUM_WORDS));

    //////////////////////////////////////////////////
    // word index, frame end and status
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            next_index    <= `ADDR_W'(1);
            wr_valid_q    <= 1'b0;
            frame_end     <= 1'b0;
            ready_q       <= 1'b0;
            frame_count_q <= '0;
        end
        else
        begin
            wr_valid_q <= word_valid;
            frame_end  <= word_valid && last_word;

            if (sync_hit)
            begin
                // new frame, restart at the first data word
                next_index <= `ADDR_W'(1);
                ready_q    <= 1'b0;
            end
            else if (word_valid)
            begin
                if (last_word)
                begin
                    next_index    <= `ADDR_W'(1);
                    ready_q       <= 1'b1;
                    frame_count_q <= frame_count_q + 16'd1;
                end
                else
                begin
                    next_index <= next_index + `ADDR_W'(1);
                end
            end
        end
    end

    // write payload, qualified by wr_valid_q
    always_ff @(posedge clk)
    begin
        if (word_valid)
        begin
            wr_index_q <= next_index;
            wr_data_q  <= word_data;
        end
    end

    assign wr = '{valid: wr_valid_q, index: wr_index_q, data: wr_data_q};

    assign status = '{frame_count: frame_count_q, reserved: '0, ready: ready_q};

endmodule

// ==== word_store.sv ====
`timescale 1ns/1ns

`include "frame_loader_params.svh"

module word_store
(
    input  logic                       clk,
    input  logic                       reset,
    input  frame_loader_pkg::word_wr_t wr,
    input  frame_loader_pkg::status_t  status,
    input  frame_loader_pkg::rd_req_t  rd_req,
    output frame_loader_pkg::rd_rsp_t  rd_rsp
);

    import frame_loader_pkg::*;

    // data words, address 0 has no storage
    logic [`WORD_W-1:0] mem [1:`NUM_WORDS];

    logic               wr_in_range;

    // read word before and after the handshake latch
    rd_data_u           rd_word;
    rd_data_u           rd_data_q;
    logic               ack_q;
    logic               rd_start;

    assign wr_in_range = wr.valid && (wr.index != '0) && (int'(wr.index) <= `NUM_WORDS);

    //////////////////////////////////////////////////
    // word memory
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 1; i <= `NUM_WORDS; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (wr_in_range)
        begin
            mem[wr.index] <= wr.data;
        end
    end

    // address 0 is the status view, out of range reads zero
    always_comb
    begin
        rd_word.raw = '0;
        if (rd_req.addr == '0)
        begin
            rd_word.status = status;
        end
        else if (int'(rd_req.addr) <= `NUM_WORDS)
        begin
            rd_word.raw = mem[rd_req.addr];
        end
    end

    //////////////////////////////////////////////////
    // four-phase read port
    //////////////////////////////////////////////////

    // req seen high while ack is still low
    assign rd_start = rd_req.req && !ack_q;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            ack_q <= 1'b0;
        end
        else if (rd_start)
        begin
            ack_q <= 1'b1;
        end
        else if (!rd_req.req)
        begin
            ack_q <= 1'b0;
        end
    end

    // data held steady for the whole ack phase
    always_ff @(posedge clk)
    begin
        if (rd_start)
        begin
            rd_data_q <= rd_word;
        end
    end

    assign rd_rsp = '{ack: ack_q, data: rd_data_q};

endmodule

// ==== frame_loader.sv ====
`timescale 1ns/1ns

`include "frame_loader_params.svh"

module frame_loader
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      serial_in,
    input  frame_loader_pkg::rd_req_t rd_req,
    output frame_loader_pkg::rd_rsp_t rd_rsp
);

    import frame_loader_pkg::*;

    // deserializer to sequencer
    logic               word_valid;
    logic [`WORD_W-1:0] word_data;
    logic               sync_hit;
    logic               frame_end;

    // sequencer to store
    word_wr_t           wr;
    status_t            status;

    //////////////////////////////////////////////////
    // serial side
    //////////////////////////////////////////////////

    bit_deserializer i_deserializer
    (
        .clk        (clk),
        .reset      (reset),
        .serial_in  (serial_in),
        .frame_end  (frame_end),
        .word_valid (word_valid),
        .word_data  (word_data),
        .sync_hit   (sync_hit)
    );

    frame_sequencer i_sequencer
    (
        .clk        (clk),
        .reset      (reset),
        .word_valid (word_valid),
        .word_data  (word_data),
        .sync_hit   (sync_hit),
        .frame_end  (frame_end),
        .wr         (wr),
        .status     (status)
    );

    // host side
    word_store i_store
    (
        .clk    (clk),
        .reset  (reset),
        .wr     (wr),
        .status (status),
        .rd_req (rd_req),
        .rd_rsp (rd_rsp)
    );

endmodule

// ==== tb_frame_loader.sv ====
`timescale 1ns/1ns

`include "frame_loader_params.svh"

module tb_frame_loader;

    import frame_loader_pkg::*;

    logic               clk;
    logic               reset;
    logic               serial_in;
    rd_req_t            rd_req;
    rd_rsp_t            rd_rsp;

    // stimulus source and expected store contents
    logic [31:0]        lfsr_state;
    logic [`WORD_W-1:0] exp_words [1:`NUM_WORDS];

    int                 error_count;
    int                 timeout_count;

    frame_loader i_dut
    (
        .clk       (clk),
        .reset     (reset),
        .serial_in (serial_in),
        .rd_req    (rd_req),
        .rd_rsp    (rd_rsp)
    );

    always #20 clk = ~clk;

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one step per bit of the word
    task automatic random_word(output logic [`WORD_W-1:0] w);
        w = '0;
        for (int i = 0; i < `WORD_W; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            w = {w[`WORD_W-2:0], lfsr_state[0]};
        end
    endtask

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected)
        begin
            error_count++;
            $display("** Error at %0t ns: %s, got %h, expected %h",
                     $time, msg, actual, expected);
        end
    endtask

    // msb first and one bit per clock
    task automatic send_bits(input logic [`WORD_W-1:0] w, input int nbits);
        for (int i = nbits - 1; i >= 0; i--)
        begin
            @(posedge clk);
            #5;
            serial_in = w[i];
        end
    endtask

    task automatic wait_for_ack(input logic level, input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (rd_rsp.ack !== level && cycles < 20)
        begin
            @(negedge clk);
            cycles++;
        end
        if (rd_rsp.ack !== level)
        begin
            timeout_count++;
            $display("timeout at %0t ns: ack never went to %0d during %s",
                     $time, level, what);
        end
    endtask

    // one full four-phase read
    task automatic read_word(input logic [`ADDR_W-1:0] addr, output rd_data_u data);
        @(posedge clk);
        #5;
        rd_req.addr = addr;
        rd_req.req  = 1'b1;
        wait_for_ack(1'b1, $sformatf("read of address %0d", addr));
        data = rd_rsp.data;
        @(posedge clk);
        #5;
        rd_req.req = 1'b0;
        wait_for_ack(1'b0, $sformatf("release of address %0d", addr));
    endtask

    task automatic check_status(input logic exp_ready, input logic [15:0] exp_count,
                                input string tag);
        rd_data_u d;
        read_word('0, d);
        check(32'(d.status.ready), 32'(exp_ready), {tag, ": status ready"});
        check(32'(d.status.frame_count), 32'(exp_count), {tag, ": frame count"});
    endtask

    task automatic check_frame(input string tag);
        rd_data_u d;
        for (int a = 1; a <= `NUM_WORDS; a++)
        begin
            read_word(`ADDR_W'(a), d);
            check(d.raw, exp_words[a], $sformatf("%s: word %0d", tag, a));
        end
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////

    task automatic test_reset_state();
        rd_data_u d;
        check_status(1'b0, 16'd0, "reset");
        read_word(`ADDR_W'(1), d);
        check(d.raw, '0, "reset: word 1");
        read_word(`ADDR_W'(32), d);
        check(d.raw, '0, "reset: word 32");
        read_word(`ADDR_W'(`NUM_WORDS), d);
        check(d.raw, '0, "reset: last word");
    endtask

    task automatic test_full_frame();
        send_bits('0, 32);
        send_bits('0, 8);
        send_bits(`SYNC_WORD, 32);
        for (int a = 1; a <= `NUM_WORDS; a++)
        begin
            random_word(exp_words[a]);
            send_bits(exp_words[a], 32);
        end
        send_bits('0, 4);
        check_frame("frame 1");
        check_status(1'b1, 16'd1, "frame 1");
    endtask

    // zeros after the bad sync keep any shifted window from matching
    task automatic test_false_sync();
        send_bits(`SYNC_WORD ^ 32'h1, 32);
        send_bits('0, 32);
        send_bits(32'h1234_5678, 32);
        send_bits('0, 8);
        check_frame("false sync");
        check_status(1'b1, 16'd1, "false sync");
    endtask

    task automatic test_second_frame();
        rd_data_u d;
        for (int a = 1; a <= `NUM_WORDS; a++)
        begin
            random_word(exp_words[a]);
        end
        send_bits(`SYNC_WORD, 32);
        send_bits(exp_words[1], 32);
        // stream keeps running while the host reads mid-frame
        fork
            begin
                for (int a = 2; a <= `NUM_WORDS; a++)
                begin
                    send_bits(exp_words[a], 32);
                end
            end
            begin
                repeat (3) @(posedge clk);
                check_status(1'b0, 16'd1, "frame 2 start");
                read_word(`ADDR_W'(1), d);
                check(d.raw, exp_words[1], "frame 2 start: word 1");
            end
        join
        send_bits('0, 4);
        check_status(1'b1, 16'd2, "frame 2");
        check_frame("frame 2");
    endtask

    task automatic test_read_handshake();
        @(posedge clk);
        #5;
        rd_req.addr = `ADDR_W'(5);
        rd_req.req  = 1'b1;
        wait_for_ack(1'b1, "held read");
        check(rd_rsp.data.raw, exp_words[5], "held read: word 5");
        repeat (5)
        begin
            @(negedge clk);
            check(32'(rd_rsp.ack), 32'd1, "held read: ack while req high");
        end
        @(posedge clk);
        #5;
        rd_req.req = 1'b0;
        wait_for_ack(1'b0, "held read release");
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial
    begin
        clk           = 1'b0;
        reset         = 1'b1;
        serial_in     = 1'b0;
        rd_req        = '0;
        lfsr_state    = 32'h89c;
        error_count   = 0;
        timeout_count = 0;
        for (int a = 1; a <= `NUM_WORDS; a++)
        begin
            exp_words[a] = '0;
        end

        repeat (2) @(posedge clk);
        #5;
        reset = 1'b0;

        test_reset_state();
        test_full_frame();
        test_false_sync();
        test_second_frame();
        test_read_handshake();

        $display("errors: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0)
        begin
            $display("TEST RESULT: PASS");
        end
        else
        begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== frame_loader.f ====
+incdir+.
frame_loader_pkg.sv
bit_deserializer.sv
frame_sequencer.sv
word_store.sv
frame_loader.sv
tb_frame_loader.sv

// ==== Makefile ====
# Verilator build for the serial frame loader

VERILATOR ?= verilator
TOP       ?= tb_frame_loader
FILELIST  ?= frame_loader.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ns
VFLAGS    ?= --binary --timing -j 0
FAIL_MSG  ?= TEST RESULT: FAIL

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST)))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES) frame_loader_params.svh
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then echo "simulator exited with status $$status"; exit 1; fi
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
